/* Bender.yml */
package:
  name: blas_engine

export_include_dirs:
  - hw

sources:
  - files:
      - hw/blas_pkg.sv
      - hw/blas_regs.sv
      - hw/blas_sequencer.sv
      - hw/tpu_lane.sv
      - hw/commit_agg.sv
      - hw/blas_engine.sv
  - target: test
    files:
      - testbench/blas_engine_props.sv
      - testbench/blas_engine_tb.sv

/* hw/blas_engine.sv */
// Top level with register block, sequencer, commit aggregator and lane array
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module blas_engine (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [7:0]               wb_adr,
	input  logic [`BLAS_DATA_W-1:0]  wb_dat_i,
	output logic [`BLAS_DATA_W-1:0]  wb_dat_o,
	output logic                     wb_ack
);

	import blas_pkg::*;

	logic                                         busy;
	logic [`BLAS_ISSUE_W-1:0]                     last_no;
	logic [`BLAS_ISSUE_W-1:0]                     next_no;
	logic [`BLAS_DATA_W-1:0]                      alpha;
	logic                                         issue_req;
	instr_u                                       issue_instr;
	logic [`BLAS_NUM_LANES-1:0]                   lane_en;
	logic                                         lane_start;
	instr_u                                       lane_instr;
	logic [`BLAS_NUM_LANES-1:0]                   lane_go;
	logic [`BLAS_NUM_LANES-1:0]                   lane_term;
	logic                                         commit_req;
	logic                                         mem_we;
	logic [`BLAS_ADR_W-1:0]                       mem_adr;
	logic [`BLAS_LANE_W-1:0]                      mem_lane;
	logic [`BLAS_DATA_W-1:0]                      mem_wdata;
	logic [`BLAS_NUM_LANES-1:0][`BLAS_DATA_W-1:0] mem_rdata;
	logic [`BLAS_NUM_LANES-1:0]                   lane_we;

	blas_regs u_regs (
		.clock(clock), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.busy(busy), .last_no(last_no), .next_no(next_no), .alpha(alpha),
		.issue_req(issue_req), .issue_instr(issue_instr), .lane_en(lane_en),
		.mem_we(mem_we), .mem_adr(mem_adr), .mem_lane(mem_lane),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	blas_sequencer u_seq (
		.clock(clock), .rst_n(rst_n),
		.issue_req(issue_req), .issue_instr(issue_instr), .lane_en(lane_en),
		.commit_req(commit_req), .lane_start(lane_start), .lane_instr(lane_instr),
		.lane_go(lane_go), .alpha(alpha), .busy(busy),
		.last_no(last_no), .next_no(next_no)
	);

	commit_agg u_agg (
		.clock(clock), .rst_n(rst_n),
		.start(lane_start), .go(lane_go), .term(lane_term), .commit_req(commit_req)
	);

	for (genvar i = 0; i < `BLAS_NUM_LANES; i++) begin : g_lane
		assign lane_we[i] = mem_we && (mem_lane == i);  // Host window lane select

		tpu_lane u_lane (
			.clock(clock), .rst_n(rst_n),
			.start(lane_start), .go(lane_go[i]), .instr(lane_instr), .alpha(alpha),
			.term(lane_term[i]), .mem_we(lane_we[i]), .mem_adr(mem_adr),
			.mem_wdata(mem_wdata), .mem_rdata(mem_rdata[i])
		);
	end

endmodule

`default_nettype wire

/* hw/blas_macros.svh */
// Size macros for data width, lane count, memory depth and issue numbering
`ifndef BLAS_MACROS_SVH
`define BLAS_MACROS_SVH

// Datapath and array size
`define BLAS_DATA_W     32
`define BLAS_NUM_LANES  2
`define BLAS_MEM_DEPTH  16

// Issue number width, wraps at 16
`define BLAS_ISSUE_W    4

// Derived index widths
`define BLAS_ADR_W      $clog2(`BLAS_MEM_DEPTH)
`define BLAS_LANE_W     $clog2(`BLAS_NUM_LANES)

`endif

/* hw/blas_pkg.sv */
// Opcode enum and instruction word union for the engine
`default_nettype none

package blas_pkg;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_SETA = 4'h1,  // Load alpha from immediate
		OP_AXPY = 4'h2,
		OP_VADD = 4'h3,
		OP_VMUL = 4'h4
	} opcode_e;

	// One instruction word, decoded as vector form or scalar form
	typedef union packed {
		struct packed {
			opcode_e     op;
			logic [3:0]  dst;
			logic [3:0]  src_a;
			logic [3:0]  src_b;
			logic [3:0]  len;    // Element count minus one
			logic [11:0] pad;
		} vec;
		struct packed {
			opcode_e            op;
			logic signed [15:0] imm;
			logic [11:0]        pad;
		} scl;
	} instr_u;

endpackage

`default_nettype wire

/* hw/blas_regs.sv */
// Wishbone classic slave with register map, memory window decode and host stall
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module blas_regs (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [7:0]                    wb_adr,
	input  logic [`BLAS_DATA_W-1:0]       wb_dat_i,
	output logic [`BLAS_DATA_W-1:0]       wb_dat_o,
	output logic                          wb_ack,
	input  logic                          busy,
	input  logic [`BLAS_ISSUE_W-1:0]      last_no,
	input  logic [`BLAS_ISSUE_W-1:0]      next_no,
	input  logic [`BLAS_DATA_W-1:0]       alpha,
	output logic                          issue_req,
	output blas_pkg::instr_u              issue_instr,
	output logic [`BLAS_NUM_LANES-1:0]    lane_en,
	output logic                          mem_we,
	output logic [`BLAS_ADR_W-1:0]        mem_adr,
	output logic [`BLAS_LANE_W-1:0]       mem_lane,
	output logic [`BLAS_DATA_W-1:0]       mem_wdata,
	input  logic [`BLAS_NUM_LANES-1:0][`BLAS_DATA_W-1:0] mem_rdata
);

	localparam logic [4:0] REG_CTRL   = 5'h0;
	localparam logic [4:0] REG_STATUS = 5'h1;
	localparam logic [4:0] REG_INSTR  = 5'h2;
	localparam logic [4:0] REG_ALPHA  = 5'h3;

	logic sel_mem;
	logic sel_ctrl;
	logic sel_instr;
	logic stall;
	logic access;

	assign sel_mem   = wb_adr[7];  // 0x80..0xFF
	assign sel_ctrl  = !wb_adr[7] && (wb_adr[6:2] == REG_CTRL);
	assign sel_instr = !wb_adr[7] && (wb_adr[6:2] == REG_INSTR);

	// Back-pressure on issue and memory while lanes run
	assign stall  = busy && (sel_mem || (sel_instr && wb_we));
	assign access = wb_cyc && wb_stb && !wb_ack && !stall;

	assign mem_we    = access && wb_we && sel_mem;
	assign mem_adr   = wb_adr[2 +: `BLAS_ADR_W];
	assign mem_lane  = wb_adr[6 +: `BLAS_LANE_W];
	assign mem_wdata = wb_dat_i;

	always_comb begin
		wb_dat_o = '0;
		if (sel_mem) begin
			wb_dat_o = mem_rdata[mem_lane];
		end else begin
			case (wb_adr[6:2])
				REG_CTRL:   wb_dat_o[`BLAS_NUM_LANES-1:0] = lane_en;
				REG_STATUS: begin
					wb_dat_o[0]                 = busy;
					wb_dat_o[4 +: `BLAS_ISSUE_W] = last_no;
					wb_dat_o[8 +: `BLAS_ISSUE_W] = next_no;
				end
				REG_ALPHA:  wb_dat_o = alpha;
				default:    wb_dat_o = '0;  // INSTR is write-only
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_ack    <= 1'b0;
			issue_req <= 1'b0;
			lane_en   <= '1;
		end else begin
			wb_ack    <= access;  // One-cycle pulse
			issue_req <= access && wb_we && sel_instr;
			if (access && wb_we && sel_ctrl)
				lane_en <= wb_dat_i[`BLAS_NUM_LANES-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (access && wb_we && sel_instr)
			issue_instr <= wb_dat_i;
	end

endmodule

`default_nettype wire

/* hw/blas_sequencer.sv */
// Issue control, issue numbering, scalar register, busy and commit tracking
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module blas_sequencer (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          issue_req,
	input  blas_pkg::instr_u              issue_instr,
	input  logic [`BLAS_NUM_LANES-1:0]    lane_en,
	input  logic                          commit_req,
	output logic                          lane_start,
	output blas_pkg::instr_u              lane_instr,
	output logic [`BLAS_NUM_LANES-1:0]    lane_go,
	output logic [`BLAS_DATA_W-1:0]       alpha,
	output logic                          busy,
	output logic [`BLAS_ISSUE_W-1:0]      last_no,
	output logic [`BLAS_ISSUE_W-1:0]      next_no
);

	import blas_pkg::*;

	logic is_vec;
	logic dispatch;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb begin
		case (issue_instr.vec.op)
			OP_AXPY, OP_VADD, OP_VMUL: is_vec = 1'b1;
			default:                   is_vec = 1'b0;
		endcase
	end

	// Empty mask retires locally like a scalar op
	assign dispatch = issue_req && is_vec && (|lane_en);

	////////////////////////////////////////////////////////////
	// Issue and commit
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lane_start <= 1'b0;
			lane_go    <= '0;
			alpha      <= '0;
			busy       <= 1'b0;
			last_no    <= '0;
			next_no    <= '0;
		end else begin
			lane_start <= dispatch;
			if (commit_req) begin
				busy    <= 1'b0;
				last_no <= next_no - 1'b1;  // Only one op in flight
			end
			if (issue_req) begin
				next_no <= next_no + 1'b1;
				if (!dispatch)
					last_no <= next_no;
			end
			if (dispatch) begin
				busy    <= 1'b1;
				lane_go <= lane_en;
			end
			if (issue_req && (issue_instr.scl.op == OP_SETA))
				alpha <= {{(`BLAS_DATA_W-16){issue_instr.scl.imm[15]}}, issue_instr.scl.imm};
		end
	end

	// Held stable for the lanes until the next dispatch
	always_ff @(posedge clock) begin
		if (dispatch)
			lane_instr <= issue_instr;
	end

endmodule

`default_nettype wire

/* hw/commit_agg.sv */
// Commit aggregator that merges lane termination flags into one commit per issue
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module commit_agg (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [`BLAS_NUM_LANES-1:0]  go,
	input  logic [`BLAS_NUM_LANES-1:0]  term,
	output logic                        commit_req
);

	logic [`BLAS_NUM_LANES-1:0] expect_set;
	logic [`BLAS_NUM_LANES-1:0] done_set;
	logic [`BLAS_NUM_LANES-1:0] done_next;
	logic                       pending;
	logic                       all_done;

	assign done_next = done_set | (term & expect_set);  // Ignore idle lanes
	assign all_done  = pending && (done_next == expect_set);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			expect_set <= '0;
			done_set   <= '0;
			pending    <= 1'b0;
			commit_req <= 1'b0;
		end else begin
			commit_req <= all_done;
			if (start) begin
				expect_set <= go;
				done_set   <= '0;
				pending    <= |go;
			end else if (all_done) begin
				expect_set <= '0;
				done_set   <= '0;
				pending    <= 1'b0;
			end else if (pending) begin
				done_set <= done_next;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/tpu_lane.sv */
// Thread lane with local data memory, element counter and arithmetic datapath
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module tpu_lane (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic                       go,
	input  blas_pkg::instr_u           instr,
	input  logic [`BLAS_DATA_W-1:0]    alpha,
	output logic                       term,
	input  logic                       mem_we,
	input  logic [`BLAS_ADR_W-1:0]     mem_adr,
	input  logic [`BLAS_DATA_W-1:0]    mem_wdata,
	output logic [`BLAS_DATA_W-1:0]    mem_rdata
);

	import blas_pkg::*;

	logic [`BLAS_DATA_W-1:0] mem [`BLAS_MEM_DEPTH];

	logic                    active;
	logic [`BLAS_ADR_W-1:0]  idx;
	logic [`BLAS_ADR_W-1:0]  adr_a;
	logic [`BLAS_ADR_W-1:0]  adr_b;
	logic [`BLAS_ADR_W-1:0]  adr_d;
	logic [`BLAS_DATA_W-1:0] opa;
	logic [`BLAS_DATA_W-1:0] opb;
	logic [`BLAS_DATA_W-1:0] result;

	////////////////////////////////////////////////////////////
	// Element counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active <= 1'b0;
			idx    <= '0;
		end else if (start && go) begin
			active <= 1'b1;
			idx    <= '0;
		end else if (active) begin
			if (idx == instr.vec.len)
				active <= 1'b0;
			idx <= idx + 1'b1;
		end
	end

	assign term = active && (idx == instr.vec.len);  // Last write

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////
	assign adr_a = instr.vec.src_a + idx;  // Base indices wrap in memory
	assign adr_b = instr.vec.src_b + idx;
	assign adr_d = instr.vec.dst + idx;

	assign opa = mem[adr_a];
	assign opb = mem[adr_b];

	always_comb begin
		case (instr.vec.op)
			OP_AXPY: result = alpha * opa + opb;
			OP_VADD: result = opa + opb;
			OP_VMUL: result = opa * opb;  // Low word of product
			default: result = opa;
		endcase
	end

	// Lane writes while running, host writes when idle
	always_ff @(posedge clock) begin
		if (active)
			mem[adr_d] <= result;
		else if (mem_we)
			mem[mem_adr] <= mem_wdata;
	end

	assign mem_rdata = mem[mem_adr];

endmodule

`default_nettype wire

/* testbench/blas_engine_props.sv */
// Bus handshake and busy assertions, bound into the engine top level
`timescale 1ns/1ns
`default_nettype none

module blas_engine_props (
	input wire logic       clock,
	input wire logic       rst_n,
	input wire logic       wb_cyc,
	input wire logic       wb_stb,
	input wire logic       wb_we,
	input wire logic [7:0] wb_adr,
	input wire logic       wb_ack,
	input wire logic       busy
);

	int fail_count = 0;  // Read by the testbench at the end

	ack_with_request: assert property (@(posedge clock) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin
			$error("ack without an active cycle and strobe");
			fail_count++;
		end

	ack_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			$error("ack held for two cycles in a row");
			fail_count++;
		end

	// Busy only rises after an acked INSTR write on the bus
	busy_after_issue: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(busy) |-> $past(wb_ack && wb_we && (wb_adr == 8'h08)))
		else begin
			$error("busy rose without an issue");
			fail_count++;
		end

endmodule

bind blas_engine blas_engine_props props_i (
	.clock(clock), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
	.wb_we(wb_we), .wb_adr(wb_adr), .wb_ack(wb_ack), .busy(busy)
);

`default_nettype wire

/* testbench/blas_engine_tb.sv */
// Testbench for the engine: clock, reset, Wishbone bus tasks, directed tests, report
`timescale 1ns/1ns
`default_nettype none
`include "blas_macros.svh"

module blas_engine_tb;

	import blas_pkg::*;

	localparam logic [7:0] ADR_CTRL   = 8'h00;
	localparam logic [7:0] ADR_STATUS = 8'h04;
	localparam logic [7:0] ADR_INSTR  = 8'h08;
	localparam logic [7:0] ADR_ALPHA  = 8'h0C;
	localparam int TIMEOUT = 200;
	localparam int NL = `BLAS_NUM_LANES;
	localparam int DEPTH = `BLAS_MEM_DEPTH;

	logic        clock;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [7:0]  wb_adr;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack;

	// Reference model of the lane memories and engine state
	logic [31:0]   model_mem [NL][DEPTH];
	logic [31:0]   alpha_model;
	logic [NL-1:0] mask_model;
	int issue_cnt = 0;
	int cycle_cnt = 0;
	int ack_wait = 0;
	int error_count = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_passed = 0;
	string cur_test;

	blas_engine dut_i (
		.clock(clock), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////////////////
	task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
		int waited;
		@(posedge clock);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_i <= data;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!wb_ack && waited < TIMEOUT);
		if (!wb_ack) begin
			$display("ERROR in %s: no ack for write to %h within %0d cycles",
				cur_test, adr, TIMEOUT);
			error_count++;
		end
		ack_wait = waited;
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
		int waited;
		@(posedge clock);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b0;
		wb_adr   <= adr;
		wb_dat_i <= '0;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!wb_ack && waited < TIMEOUT);
		if (!wb_ack) begin
			$display("ERROR in %s: no ack for read of %h within %0d cycles",
				cur_test, adr, TIMEOUT);
			error_count++;
		end
		data = wb_dat_o;  // Stable at the falling edge
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int start;
		start = cycle_cnt;
		wb_read(ADR_STATUS, st);
		while (st[0] && (cycle_cnt - start) < TIMEOUT)
			wb_read(ADR_STATUS, st);
		if (st[0]) begin
			$display("ERROR in %s: engine still busy after %0d cycles", cur_test, TIMEOUT);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Model and helpers
	//////////////////////////////////////////////////////////////
	function automatic logic [7:0] mem_addr(input int lane, input int idx);
		return 8'h80 | 8'(lane << 6) | 8'(idx << 2);
	endfunction

	function automatic logic [31:0] vec_instr(input logic [3:0] op, input logic [3:0] dst,
			input logic [3:0] a, input logic [3:0] b, input logic [3:0] len);
		return {op, dst, a, b, len, 12'h000};
	endfunction

	// STATUS after cnt issues with nothing in flight
	function automatic logic [31:0] idle_status(input int cnt);
		return {20'h0, 4'(cnt), 4'(cnt - 1), 4'h0};
	endfunction

	function automatic logic [31:0] elem_result(input logic [3:0] op,
			input logic [31:0] x, input logic [31:0] y);
		logic [63:0] full;
		case (op)
			OP_AXPY: full = {32'h0, alpha_model} * {32'h0, x} + {32'h0, y};
			OP_VADD: full = {32'h0, x} + {32'h0, y};
			OP_VMUL: full = {32'h0, x} * {32'h0, y};
			default: full = {32'h0, x};
		endcase
		return full[31:0];  // Wrap at the data width
	endfunction

	function automatic void apply_vector(input logic [3:0] op, input logic [3:0] dst,
			input logic [3:0] a, input logic [3:0] b, input logic [3:0] len);
		for (int l = 0; l < NL; l++) begin
			if (mask_model[l]) begin
				for (int i = 0; i <= len; i++)
					model_mem[l][4'(dst + i)] = elem_result(op, model_mem[l][4'(a + i)],
						model_mem[l][4'(b + i)]);
			end
		end
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
		error_count++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_start_errors = error_count;
	endtask

	task automatic close_test();
		tests_run++;
		if (error_count == test_start_errors) begin
			tests_passed++;
			$display("PASS %s", cur_test);
		end else begin
			$display("FAIL %s (%0d errors)", cur_test, error_count - test_start_errors);
		end
	endtask

	task automatic set_mask(input logic [NL-1:0] m);
		wb_write(ADR_CTRL, 32'(m));
		mask_model = m;
	endtask

	task automatic issue_vector(input logic [3:0] op, input logic [3:0] dst,
			input logic [3:0] a, input logic [3:0] b, input logic [3:0] len);
		wb_write(ADR_INSTR, vec_instr(op, dst, a, b, len));
		apply_vector(op, dst, a, b, len);
		issue_cnt++;
		wait_idle();
	endtask

	task automatic verify_memory();
		logic [31:0] rd;
		for (int l = 0; l < NL; l++) begin
			for (int i = 0; i < DEPTH; i++) begin
				wb_read(mem_addr(l, i), rd);
				if (rd !== model_mem[l][i])
					report_mismatch($sformatf("lane %0d word %0d", l, i), model_mem[l][i], rd);
			end
		end
	endtask

	task automatic check_status(input string what, input logic [31:0] exp);
		logic [31:0] st;
		wb_read(ADR_STATUS, st);
		if (st !== exp)
			report_mismatch(what, exp, st);
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////
	task automatic reset_and_registers();
		logic [31:0] rd;
		start_test("reset_regs");
		check_status("STATUS after reset", 32'h0);
		wb_read(ADR_CTRL, rd);
		if (rd !== 32'(2**NL - 1))
			report_mismatch("CTRL after reset", 32'(2**NL - 1), rd);
		set_mask(1);
		wb_read(ADR_CTRL, rd);
		if (rd !== 32'h1)
			report_mismatch("CTRL readback", 32'h1, rd);
		set_mask('1);
		close_test();
	endtask

	task automatic memory_readback();
		start_test("memory");
		for (int l = 0; l < NL; l++) begin
			for (int i = 0; i < DEPTH; i++) begin
				model_mem[l][i] = $urandom();
				wb_write(mem_addr(l, i), model_mem[l][i]);
			end
		end
		verify_memory();
		close_test();
	endtask

	task automatic seta_then_axpy();
		logic [15:0] imm;
		logic [31:0] rd;
		start_test("seta_axpy");
		imm = 16'hFFFD;  // -3
		wb_write(ADR_INSTR, {OP_SETA, imm, 12'h000});
		issue_cnt++;
		alpha_model = {{16{imm[15]}}, imm};
		wb_read(ADR_ALPHA, rd);
		if (rd !== alpha_model)
			report_mismatch("ALPHA", alpha_model, rd);
		issue_vector(OP_AXPY, 4'd8, 4'd0, 4'd4, 4'd3);
		verify_memory();
		check_status("STATUS after AXPY", idle_status(issue_cnt));
		close_test();
	endtask

	task automatic lane_mask_ops();
		start_test("mask");
		set_mask(1);
		issue_vector(OP_VADD, 4'd12, 4'd0, 4'd4, 4'd3);
		verify_memory();
		set_mask('1);
		issue_vector(OP_VMUL, 4'd8, 4'd0, 4'd12, 4'd3);
		verify_memory();
		close_test();
	endtask

	task automatic backpressure_numbering();
		logic [31:0] st;
		int first_no;
		start_test("backpressure");
		first_no = issue_cnt;
		// Long op over the whole memory, doubles every word
		wb_write(ADR_INSTR, vec_instr(OP_VADD, 4'd0, 4'd0, 4'd0, 4'd15));
		apply_vector(OP_VADD, 4'd0, 4'd0, 4'd0, 4'd15);
		issue_cnt++;
		wb_read(ADR_STATUS, st);
		if (st[0] !== 1'b1)
			report_mismatch("busy while running", 32'h1, 32'(st[0]));
		wb_write(ADR_INSTR, vec_instr(OP_VADD, 4'd8, 4'd0, 4'd4, 4'd7));
		if (ack_wait < 6) begin
			$display("ERROR in %s: INSTR write while busy was acked after %0d cycles",
				cur_test, ack_wait);
			error_count++;
		end
		apply_vector(OP_VADD, 4'd8, 4'd0, 4'd4, 4'd7);
		issue_cnt++;
		wb_read(ADR_STATUS, st);
		if (st[7:4] !== 4'(first_no))
			report_mismatch("last issue after first commit", 32'(4'(first_no)), 32'(st[7:4]));
		if (st[11:8] !== 4'(issue_cnt))
			report_mismatch("next issue", 32'(4'(issue_cnt)), 32'(st[11:8]));
		wait_idle();
		verify_memory();
		// NOPs carry the numbering past the wrap
		while (issue_cnt < 20) begin
			wb_write(ADR_INSTR, {OP_NOP, 28'h0});
			issue_cnt++;
			check_status($sformatf("STATUS after issue %0d", issue_cnt), idle_status(issue_cnt));
		end
		close_test();
	endtask

	task automatic empty_mask_commit();
		start_test("empty_mask");
		set_mask('0);
		wb_write(ADR_INSTR, vec_instr(OP_VADD, 4'd0, 4'd4, 4'd8, 4'd3));
		issue_cnt++;
		check_status("STATUS after empty mask", idle_status(issue_cnt));
		verify_memory();
		set_mask('1);
		close_test();
	endtask

	initial begin
		void'($urandom(32'h3b1b));
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		alpha_model = '0;
		mask_model  = '1;
		cur_test = "reset";
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;

		reset_and_registers();
		memory_readback();
		seta_then_axpy();
		lane_mask_ops();
		backpressure_numbering();
		empty_mask_commit();

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_passed, tests_run - tests_passed, error_count,
			dut_i.props_i.fail_count);
		if (error_count == 0 && dut_i.props_i.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/blas_pkg.sv
hw/blas_regs.sv
hw/blas_sequencer.sv
hw/tpu_lane.sv
hw/commit_agg.sv
hw/blas_engine.sv
testbench/blas_engine_props.sv
testbench/blas_engine_tb.sv
